/* mem_sys_pkg.sv */
package mem_sys_pkg;

    // bus widths
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // bank geometry
    localparam int NUM_BANKS      = 4;
    localparam int BANK_WORDS     = 64;
    localparam int BANK_IDX_WIDTH = $clog2(NUM_BANKS);
    localparam int WORD_IDX_WIDTH = $clog2(BANK_WORDS);

    // address map bit positions
    localparam int REGION_BIT = 15;
    localparam int BANK_LSB   = 8;
    localparam int WORD_LSB   = 2;

    typedef enum logic {
        REGION_MEM = 1'b0,
        REGION_CFG = 1'b1
    } region_e;

    typedef struct packed {
        logic                  req;
        logic [ADDR_WIDTH-1:0] addr;
        logic                  we;
        logic [STRB_WIDTH-1:0] be;
        logic [DATA_WIDTH-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                  rvalid;
        logic                  err;
        logic [DATA_WIDTH-1:0] rdata;
    } mem_rsp_t;

    // request after decoding, as one target sees it
    typedef struct packed {
        logic                      valid;
        logic                      we;
        logic [STRB_WIDTH-1:0]     be;
        logic [WORD_IDX_WIDTH-1:0] word;
        logic [DATA_WIDTH-1:0]     wdata;
    } bank_req_t;

    typedef struct packed {
        logic                  rvalid;
        logic                  err;
        logic [DATA_WIDTH-1:0] rdata;
    } bank_rsp_t;

    typedef struct packed {
        logic rst;
        logic pause;
    } bank_ctrl_t;

endpackage

/* mem_req_router.sv */
`timescale 1ns/1ps

module mem_req_router (
    input  mem_sys_pkg::mem_req_t                             req_i,
    output mem_sys_pkg::bank_req_t [mem_sys_pkg::NUM_BANKS-1:0] bank_req_o,
    output mem_sys_pkg::bank_req_t                            cfg_req_o
);

    mem_sys_pkg::region_e                        region;
    logic [mem_sys_pkg::BANK_IDX_WIDTH-1:0]      bank_sel;
    mem_sys_pkg::bank_req_t                      base_req;

    // address fields
    assign region   = mem_sys_pkg::region_e'(req_i.addr[mem_sys_pkg::REGION_BIT]);
    assign bank_sel = req_i.addr[mem_sys_pkg::BANK_LSB +: mem_sys_pkg::BANK_IDX_WIDTH];

    // payload shared by every target, valid added per target below
    always_comb begin
        base_req       = '0;
        base_req.we    = req_i.we;
        base_req.be    = req_i.be;
        base_req.word  = req_i.addr[mem_sys_pkg::WORD_LSB +: mem_sys_pkg::WORD_IDX_WIDTH];
        base_req.wdata = req_i.wdata;
    end

    always_comb begin
        for (int i = 0; i < mem_sys_pkg::NUM_BANKS; i++) begin
            bank_req_o[i]       = base_req;
            bank_req_o[i].valid = req_i.req
                                  && (region == mem_sys_pkg::REGION_MEM)
                                  && (bank_sel == i[mem_sys_pkg::BANK_IDX_WIDTH-1:0]);
        end
    end

    // config region, register picked later by the low word bits
    always_comb begin
        cfg_req_o       = base_req;
        cfg_req_o.valid = req_i.req && (region == mem_sys_pkg::REGION_CFG);
    end

endmodule

/* mem_bank.sv */
`timescale 1ns/1ps

module mem_bank (
    input  logic                    lsdom_seq,
    input  logic                    rst_n_i,
    input  mem_sys_pkg::bank_req_t  bank_req_i,
    input  mem_sys_pkg::bank_ctrl_t ctrl_i,
    output mem_sys_pkg::bank_rsp_t  bank_rsp_o
);

    logic [mem_sys_pkg::DATA_WIDTH-1:0]     mem_q [mem_sys_pkg::BANK_WORDS];
    logic [mem_sys_pkg::WORD_IDX_WIDTH-1:0] sweep_q;

    logic                               refuse;
    logic                               do_write;
    logic                               do_read;
    logic                               rvalid_q;
    logic                               err_q;
    logic [mem_sys_pkg::DATA_WIDTH-1:0] rdata_q;

    // paused or held in soft reset: no access to the storage
    assign refuse   = ctrl_i.rst || ctrl_i.pause;
    assign do_write = bank_req_i.valid && bank_req_i.we && !refuse;
    assign do_read  = bank_req_i.valid && !bank_req_i.we && !refuse;

    // sweep pointer walks all words while rst is held
    always_ff @(posedge lsdom_seq or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sweep_q <= '0;
        end else if (ctrl_i.rst) begin
            sweep_q <= sweep_q + 1'b1;
        end else begin
            sweep_q <= '0;
        end
    end

    // storage
    always_ff @(posedge lsdom_seq) begin
        if (ctrl_i.rst) begin
            mem_q[sweep_q] <= '0;
        end else if (do_write) begin
            for (int b = 0; b < mem_sys_pkg::STRB_WIDTH; b++) begin
                if (bank_req_i.be[b]) begin
                    mem_q[bank_req_i.word][8*b +: 8] <= bank_req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // response one cycle after the request
    always_ff @(posedge lsdom_seq or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
            err_q    <= 1'b0;
        end else begin
            rvalid_q <= bank_req_i.valid;
            err_q    <= bank_req_i.valid && refuse;
        end
    end

    // zero for writes and refused accesses
    always_ff @(posedge lsdom_seq) begin
        if (do_read) begin
            rdata_q <= mem_q[bank_req_i.word];
        end else begin
            rdata_q <= '0;
        end
    end

    always_comb begin
        bank_rsp_o        = '0;
        bank_rsp_o.rvalid = rvalid_q;
        bank_rsp_o.err    = err_q;
        bank_rsp_o.rdata  = rdata_q;
    end

endmodule

/* sys_cfg_regs.sv */
`timescale 1ns/1ps

module sys_cfg_regs (
    input  logic                                                 lsdom_seq,
    input  logic                                                 rst_n_i,
    input  mem_sys_pkg::bank_req_t                               cfg_req_i,
    output mem_sys_pkg::bank_ctrl_t [mem_sys_pkg::NUM_BANKS-1:0] ctrl_o,
    output mem_sys_pkg::bank_rsp_t                               cfg_rsp_o
);

    mem_sys_pkg::bank_ctrl_t [mem_sys_pkg::NUM_BANKS-1:0] ctrl_q;

    logic [mem_sys_pkg::BANK_IDX_WIDTH-1:0] reg_sel;
    logic                                   rvalid_q;
    logic [mem_sys_pkg::DATA_WIDTH-1:0]     rdata_q;

    // address bits 3:2 land in the low bits of the word index
    assign reg_sel = cfg_req_i.word[mem_sys_pkg::BANK_IDX_WIDTH-1:0];

    // rst in wdata[0], pause in wdata[1]
    always_ff @(posedge lsdom_seq or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else if (cfg_req_i.valid && cfg_req_i.we && cfg_req_i.be[0]) begin
            ctrl_q[reg_sel].rst   <= cfg_req_i.wdata[0];
            ctrl_q[reg_sel].pause <= cfg_req_i.wdata[1];
        end
    end

    always_ff @(posedge lsdom_seq or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= cfg_req_i.valid;
        end
    end

    // read-back of the two control bits
    always_ff @(posedge lsdom_seq) begin
        rdata_q <= '0;
        if (cfg_req_i.valid && !cfg_req_i.we) begin
            rdata_q[1:0] <= {ctrl_q[reg_sel].pause, ctrl_q[reg_sel].rst};
        end
    end

    assign ctrl_o = ctrl_q;

    always_comb begin
        cfg_rsp_o        = '0;
        cfg_rsp_o.rvalid = rvalid_q;
        cfg_rsp_o.rdata  = rdata_q;
    end

endmodule

/* mem_rsp_merge.sv */
`timescale 1ns/1ps

module mem_rsp_merge (
    input  mem_sys_pkg::bank_rsp_t [mem_sys_pkg::NUM_BANKS-1:0] bank_rsp_i,
    input  mem_sys_pkg::bank_rsp_t                             cfg_rsp_i,
    output mem_sys_pkg::mem_rsp_t                              rsp_o
);

    // at most one target answers per cycle, so a plain select is enough
    always_comb begin
        rsp_o = '0;
        for (int i = 0; i < mem_sys_pkg::NUM_BANKS; i++) begin
            if (bank_rsp_i[i].rvalid) begin
                rsp_o.rvalid = 1'b1;
                rsp_o.err    = bank_rsp_i[i].err;
                rsp_o.rdata  = bank_rsp_i[i].rdata;
            end
        end
        if (cfg_rsp_i.rvalid) begin
            rsp_o.rvalid = 1'b1;
            rsp_o.err    = cfg_rsp_i.err;
            rsp_o.rdata  = cfg_rsp_i.rdata;
        end
    end

endmodule

/* mem_sys_top.sv */
`timescale 1ns/1ps

module mem_sys_top (
    input  logic                  lsdom_seq,
    input  logic                  rst_n_i,
    input  mem_sys_pkg::mem_req_t req_i,
    output mem_sys_pkg::mem_rsp_t rsp_o
);

    mem_sys_pkg::bank_req_t  [mem_sys_pkg::NUM_BANKS-1:0] bank_req;
    mem_sys_pkg::bank_rsp_t  [mem_sys_pkg::NUM_BANKS-1:0] bank_rsp;
    mem_sys_pkg::bank_ctrl_t [mem_sys_pkg::NUM_BANKS-1:0] bank_ctrl;

    mem_sys_pkg::bank_req_t cfg_req;
    mem_sys_pkg::bank_rsp_t cfg_rsp;

    // request decode
    mem_req_router i_router (
        .req_i      (req_i),
        .bank_req_o (bank_req),
        .cfg_req_o  (cfg_req)
    );

    // banks
    for (genvar i = 0; i < mem_sys_pkg::NUM_BANKS; i++) begin : gen_bank
        mem_bank i_bank (
            .lsdom_seq  (lsdom_seq),
            .rst_n_i    (rst_n_i),
            .bank_req_i (bank_req[i]),
            .ctrl_i     (bank_ctrl[i]),
            .bank_rsp_o (bank_rsp[i])
        );
    end

    // per-bank reset and pause control
    sys_cfg_regs i_cfg (
        .lsdom_seq (lsdom_seq),
        .rst_n_i   (rst_n_i),
        .cfg_req_i (cfg_req),
        .ctrl_o    (bank_ctrl),
        .cfg_rsp_o (cfg_rsp)
    );

    mem_rsp_merge i_merge (
        .bank_rsp_i (bank_rsp),
        .cfg_rsp_i  (cfg_rsp),
        .rsp_o      (rsp_o)
    );

endmodule

/* tb_mem_sys.sv */
`timescale 1ns/1ps

module tb_mem_sys;

    typedef logic [mem_sys_pkg::DATA_WIDTH-1:0] word_t;

    // the tests need about 1500 cycles, so this leaves a wide margin
    localparam int MAX_CYCLES = 20000;

    logic                  lsdom_seq = 1'b0;
    logic                  rst_n;
    mem_sys_pkg::mem_req_t req_i;
    mem_sys_pkg::mem_rsp_t rsp_o;

    word_t       shadow [mem_sys_pkg::NUM_BANKS][mem_sys_pkg::BANK_WORDS];
    logic [31:0] lfsr_q = 32'hd4473403;
    string       cur_test;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          errors_at_start = 0;
    int          cycle_cnt = 0;

    mem_sys_top i_dut (
        .lsdom_seq (lsdom_seq),
        .rst_n_i   (rst_n),
        .req_i     (req_i),
        .rsp_o     (rsp_o)
    );

    always #2 lsdom_seq = ~lsdom_seq;

    always @(posedge lsdom_seq) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // taps 32, 22, 2, 1; one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    // bits 14:10 are don't-care in the memory region
    function automatic logic [15:0] mem_addr(input logic [1:0] bank, input logic [5:0] word,
                                             input logic [4:0] alias_bits);
        return {1'b0, alias_bits, bank, word, 2'b00};
    endfunction

    function automatic logic [15:0] cfg_addr(input logic [1:0] bank);
        return {1'b1, 11'd0, bank, 2'b00};
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t wdata,
                                          input logic [mem_sys_pkg::STRB_WIDTH-1:0] be);
        word_t res;
        res = old;
        for (int b = 0; b < mem_sys_pkg::STRB_WIDTH; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_word(input string label, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            $display("Fail %s %s: expected %08h actual %08h", cur_test, label, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string label, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            $display("Fail %s %s: expected %0b actual %0b", cur_test, label, exp, act);
            errors++;
        end
    endtask

    task automatic expect_ok(input mem_sys_pkg::mem_rsp_t rsp, input word_t exp);
        check_bit("rvalid", 1'b1, rsp.rvalid);
        check_bit("err", 1'b0, rsp.err);
        check_word("rdata", exp, rsp.rdata);
    endtask

    task automatic expect_refused(input mem_sys_pkg::mem_rsp_t rsp);
        check_bit("rvalid", 1'b1, rsp.rvalid);
        check_bit("err", 1'b1, rsp.err);
        check_word("rdata", '0, rsp.rdata);
    endtask

    // sample the response of the last cycle, then drive the next request
    task automatic step(input mem_sys_pkg::mem_req_t nxt, output mem_sys_pkg::mem_rsp_t seen);
        @(posedge lsdom_seq);
        #1;
        seen  = rsp_o;
        req_i = nxt;
    endtask

    task automatic access(input logic we, input logic [15:0] addr, input logic [3:0] be,
                          input word_t wdata, output mem_sys_pkg::mem_rsp_t rsp);
        mem_sys_pkg::mem_req_t req;
        mem_sys_pkg::mem_rsp_t pre;
        req       = '0;
        req.req   = 1'b1;
        req.addr  = addr;
        req.we    = we;
        req.be    = be;
        req.wdata = wdata;
        step(req, pre);
        req = '0;
        step(req, rsp);
        // the previous response must already be gone
        check_bit("rvalid after idle", 1'b0, pre.rvalid);
    endtask

    task automatic write_ctrl(input logic [1:0] bank, input logic [1:0] val);
        mem_sys_pkg::mem_rsp_t rsp;
        access(1'b1, cfg_addr(bank), 4'h1, {30'd0, val}, rsp);
        expect_ok(rsp, '0);
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        $display("%-14s done, %0d errors", cur_test, errors - errors_at_start);
    endtask

    task automatic test_cfg_regs();
        mem_sys_pkg::mem_rsp_t rsp;
        logic [1:0]            pat [mem_sys_pkg::NUM_BANKS];
        logic [31:0]           r;
        begin_test("cfg_regs");
        for (int b = 0; b < mem_sys_pkg::NUM_BANKS; b++) begin
            access(1'b0, cfg_addr(b[1:0]), 4'h0, '0, rsp);
            expect_ok(rsp, '0);
        end
        for (int round = 0; round < 3; round++) begin
            for (int b = 0; b < mem_sys_pkg::NUM_BANKS; b++) begin
                r      = rand_bits(2);
                pat[b] = (round == 2) ? 2'b00 : r[1:0];
                write_ctrl(b[1:0], pat[b]);
            end
            // byte 0 disabled, so nothing changes
            access(1'b1, cfg_addr(2'd0), 4'he, 32'h3, rsp);
            expect_ok(rsp, '0);
            for (int b = 0; b < mem_sys_pkg::NUM_BANKS; b++) begin
                access(1'b0, cfg_addr(b[1:0]), 4'h0, '0, rsp);
                expect_ok(rsp, {30'd0, pat[b]});
            end
        end
        end_test();
    endtask

    task automatic test_byte_enable();
        mem_sys_pkg::mem_rsp_t rsp;
        logic [15:0]           addr;
        logic [31:0]           r;
        logic [1:0]            bank;
        logic [5:0]            word;
        logic [3:0]            be;
        word_t                 data;
        begin_test("byte_enable");
        // full-word fill so every byte has a known value
        for (int b = 0; b < mem_sys_pkg::NUM_BANKS; b++) begin
            for (int w = 0; w < mem_sys_pkg::BANK_WORDS; w++) begin
                addr = mem_addr(b[1:0], w[5:0], 5'd0);
                data = {addr, ~addr};
                access(1'b1, addr, 4'hf, data, rsp);
                expect_ok(rsp, '0);
                shadow[b][w] = data;
            end
        end
        for (int i = 0; i < 40; i++) begin
            r    = rand_bits(2);
            bank = r[1:0];
            r    = rand_bits(6);
            word = r[5:0];
            r    = rand_bits(4);
            be   = r[3:0];
            data = rand_bits(32);
            r    = rand_bits(5);
            access(1'b1, mem_addr(bank, word, r[4:0]), be, data, rsp);
            expect_ok(rsp, '0);
            shadow[bank][word] = merge_bytes(shadow[bank][word], data, be);
            r = rand_bits(5);
            access(1'b0, mem_addr(bank, word, r[4:0]), 4'h0, '0, rsp);
            expect_ok(rsp, shadow[bank][word]);
        end
        end_test();
    endtask

    task automatic test_back_to_back();
        mem_sys_pkg::mem_req_t req;
        mem_sys_pkg::mem_rsp_t seen;
        word_t                 exp_q [$];
        logic [31:0]           r;
        logic [1:0]            bank;
        logic [5:0]            word;
        begin_test("back_to_back");
        for (int i = 0; i < 24; i++) begin
            r    = rand_bits(2);
            bank = r[1:0];
            // few words, so reads often hit a word written just before
            r         = rand_bits(3);
            word      = {3'd0, r[2:0]};
            req       = '0;
            req.req   = 1'b1;
            req.addr  = mem_addr(bank, word, 5'd0);
            r         = rand_bits(1);
            req.we    = r[0];
            r         = rand_bits(4);
            req.be    = r[3:0];
            req.wdata = rand_bits(32);
            if (req.we) begin
                shadow[bank][word] = merge_bytes(shadow[bank][word], req.wdata, req.be);
                exp_q.push_back('0);
            end else begin
                exp_q.push_back(shadow[bank][word]);
            end
            step(req, seen);
            if (i > 0) begin
                expect_ok(seen, exp_q.pop_front());
            end
        end
        req = '0;
        step(req, seen);
        expect_ok(seen, exp_q.pop_front());
        step(req, seen);
        check_bit("rvalid after last", 1'b0, seen.rvalid);
        end_test();
    endtask

    task automatic test_pause();
        mem_sys_pkg::mem_rsp_t rsp;
        logic [31:0]           r;
        logic [1:0]            pb;
        logic [5:0]            wp;
        begin_test("pause");
        r  = rand_bits(2);
        pb = r[1:0];
        r  = rand_bits(6);
        wp = r[5:0];
        write_ctrl(pb, 2'b10);
        access(1'b0, mem_addr(pb, wp, 5'd0), 4'h0, '0, rsp);
        expect_refused(rsp);
        access(1'b1, mem_addr(pb, wp, 5'd0), 4'hf, rand_bits(32), rsp);
        expect_refused(rsp);
        for (int b = 0; b < mem_sys_pkg::NUM_BANKS; b++) begin
            if (b[1:0] != pb) begin
                access(1'b0, mem_addr(b[1:0], wp, 5'd0), 4'h0, '0, rsp);
                expect_ok(rsp, shadow[b][wp]);
            end
        end
        write_ctrl(pb, 2'b00);
        // contents survive the pause, refused write included
        for (int w = 0; w < mem_sys_pkg::BANK_WORDS; w++) begin
            access(1'b0, mem_addr(pb, w[5:0], 5'd0), 4'h0, '0, rsp);
            expect_ok(rsp, shadow[pb][w]);
        end
        end_test();
    endtask

    task automatic test_soft_reset();
        mem_sys_pkg::mem_req_t idle;
        mem_sys_pkg::mem_rsp_t rsp;
        logic [31:0]           r;
        logic [1:0]            rb;
        begin_test("soft_reset");
        idle = '0;
        r    = rand_bits(2);
        rb   = r[1:0];
        write_ctrl(rb, 2'b01);
        access(1'b0, mem_addr(rb, 6'd0, 5'd0), 4'h0, '0, rsp);
        expect_refused(rsp);
        access(1'b1, mem_addr(rb, 6'd5, 5'd0), 4'hf, rand_bits(32), rsp);
        expect_refused(rsp);
        repeat (mem_sys_pkg::BANK_WORDS + 2) begin
            step(idle, rsp);
        end
        write_ctrl(rb, 2'b00);
        for (int w = 0; w < mem_sys_pkg::BANK_WORDS; w++) begin
            shadow[rb][w] = '0;
        end
        for (int b = 0; b < mem_sys_pkg::NUM_BANKS; b++) begin
            for (int w = 0; w < mem_sys_pkg::BANK_WORDS; w++) begin
                access(1'b0, mem_addr(b[1:0], w[5:0], 5'd0), 4'h0, '0, rsp);
                expect_ok(rsp, shadow[b][w]);
            end
        end
        end_test();
    endtask

    initial begin
        rst_n = 1'b0;
        req_i = '0;
        repeat (16) @(posedge lsdom_seq);
        #1;
        rst_n = 1'b1;
        // control registers first, while memory contents are still unknown
        test_cfg_regs();
        test_byte_enable();
        test_back_to_back();
        test_pause();
        test_soft_reset();
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sim.f */
mem_sys_pkg.sv
mem_req_router.sv
mem_bank.sv
sys_cfg_regs.sv
mem_rsp_merge.sv
mem_sys_top.sv
tb_mem_sys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_sys
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Test completed successfully

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
